/* Makefile */
SRCS := $(wildcard logic/*.sv logic/*.svh testbench/*.sv) filelist.f

.PHONY: all run clean

all: run

obj_dir/VrenameTb: $(SRCS)
	verilator --binary --timing -f filelist.f --top-module renameTb -o VrenameTb

run: obj_dir/VrenameTb
	@out="$$(./obj_dir/VrenameTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf obj_dir

/* filelist.f */
+incdir+logic
logic/renamePkg.sv
logic/uopPkg.sv
logic/uopReceiver.sv
logic/renameTable.sv
logic/tagBuffer.sv
logic/renameCore.sv
logic/uopSender.sv
logic/renameTop.sv
testbench/renameChecker.sv
testbench/renameTb.sv

/* logic/renameCore.sv */
`timescale 1ns/1ns

`include "rename_cfg.svh"

module renameCore (
    input  logic             clk,
    input  logic             rst,
    input  logic             bufValid,
    input  uopPkg::DecUop    bufUop,
    output logic             take,
    input  logic             senderFree,
    output logic             issueValid,
    output uopPkg::RenUop    issueUop,
    input  renamePkg::WbPort wbIn,
    input  uopPkg::CommitUop commitIn
);

    renamePkg::Tag     tagA;
    renamePkg::Tag     tagB;
    logic              availA;
    logic              availB;
    renamePkg::Tag     prevTag;
    renamePkg::Tag     commitPrevTag;
    renamePkg::Tag     newTag;
    logic [`TAG_W-1:0] freeTag;
    logic              freeAvail;
    logic              isLi;
    logic              needTag;
    renamePkg::SqN     sqCount;

    assign isLi = (bufUop.fu == uopPkg::FU_LI);
    // Writes to register 0 and load-immediates are eliminated here
    assign needTag = (bufUop.rd != '0) && !isLi;
    // Stall while a tag is needed and none is free
    assign take = bufValid && senderFree && (!needTag || freeAvail);

    always_comb begin
        if (needTag)
            newTag = {1'b0, freeTag};
        else if (isLi)
            newTag = {1'b1, bufUop.imm[`TAG_W-1:0]};
        else
            newTag = renamePkg::TAG_ZERO;
    end

    renameTable table0 (
        .clk(clk),
        .rst(rst),
        .lookupA(bufUop.rs1),
        .lookupB(bufUop.rs2),
        .tagA(tagA),
        .tagB(tagB),
        .availA(availA),
        .availB(availB),
        .issueValid(take),
        .issueRd(bufUop.rd),
        .issueTag(newTag),
        .issueAvail(isLi),
        .prevTag(prevTag),
        .wbIn(wbIn),
        .commitIn(commitIn),
        .commitPrevTag(commitPrevTag)
    );

    // Freed tags return unless they were special values
    tagBuffer freeList0 (
        .clk(clk),
        .rst(rst),
        .pop(take && needTag),
        .freeTag(freeTag),
        .freeAvail(freeAvail),
        .push(commitIn.valid && commitIn.rd != '0 && !commitPrevTag[`TAG_W]),
        .pushTag(commitPrevTag[`TAG_W-1:0])
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            issueValid <= 1'b0;
            sqCount <= '0;
        end else begin
            issueValid <= take;
            if (take)
                sqCount <= sqCount + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            issueUop <= uopPkg::RenUop'{
                tagA:    tagA,
                availA:  availA,
                tagB:    tagB,
                availB:  availB,
                tagDst:  newTag,
                prevTag: prevTag,
                rd:      bufUop.rd,
                sqN:     sqCount,
                imm:     bufUop.imm,
                fu:      bufUop.fu
            };
        end
    end

endmodule

/* logic/renamePkg.sv */
`include "rename_cfg.svh"

package renamePkg;

    // Physical tag with a flag bit on top
    // Flagged tags carry a load-immediate value in the low bits
    typedef logic [`TAG_W:0] Tag;

    // Register 0 never names a physical register
    localparam Tag TAG_ZERO = {1'b1, {`TAG_W{1'b0}}};

    typedef logic [`SQN_W-1:0] SqN;

    // Writeback pulse from the back end
    typedef struct packed {
        logic valid;
        Tag   tag;
    } WbPort;

    // Shared by both four-phase link sides
    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        WAIT_LOW
    } LinkState;

endpackage

/* logic/renameTable.sv */
`timescale 1ns/1ns

`include "rename_cfg.svh"

module renameTable (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`ARCH_W-1:0]   lookupA,
    input  logic [`ARCH_W-1:0]   lookupB,
    output renamePkg::Tag        tagA,
    output renamePkg::Tag        tagB,
    output logic                 availA,
    output logic                 availB,
    input  logic                 issueValid,
    input  logic [`ARCH_W-1:0]   issueRd,
    input  renamePkg::Tag        issueTag,
    input  logic                 issueAvail,
    output renamePkg::Tag        prevTag,
    input  renamePkg::WbPort     wbIn,
    input  uopPkg::CommitUop     commitIn,
    output renamePkg::Tag        commitPrevTag
);

    // Speculative mapping with ready bits
    renamePkg::Tag specTag [`NUM_ARCH_REGS];
    logic          specReady [`NUM_ARCH_REGS];

    // Committed mapping
    renamePkg::Tag commTag [`NUM_ARCH_REGS];

    // Register 0 is hardwired
    always_comb begin
        tagA = (lookupA == '0) ? renamePkg::TAG_ZERO : specTag[lookupA];
        availA = (lookupA == '0) ? 1'b1 : specReady[lookupA];
        tagB = (lookupB == '0) ? renamePkg::TAG_ZERO : specTag[lookupB];
        availB = (lookupB == '0) ? 1'b1 : specReady[lookupB];
        prevTag = (issueRd == '0) ? renamePkg::TAG_ZERO : specTag[issueRd];
        commitPrevTag = (commitIn.rd == '0) ? renamePkg::TAG_ZERO : commTag[commitIn.rd];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
                specTag[i] <= renamePkg::Tag'(i);
                specReady[i] <= 1'b1;
                commTag[i] <= renamePkg::Tag'(i);
            end
        end else begin
            // Flagged tags never wait for a result
            if (wbIn.valid && !wbIn.tag[`TAG_W]) begin
                for (int i = 1; i < `NUM_ARCH_REGS; i++) begin
                    if (specTag[i] == wbIn.tag)
                        specReady[i] <= 1'b1;
                end
            end

            // A new mapping overrides a writeback to the old one
            if (issueValid && issueRd != '0) begin
                specTag[issueRd] <= issueTag;
                specReady[issueRd] <= issueAvail;
            end

            if (commitIn.valid && commitIn.rd != '0)
                commTag[commitIn.rd] <= commitIn.tagDst;
        end
    end

endmodule

/* logic/renameTop.sv */
`timescale 1ns/1ns

module renameTop (
    input  logic             clk,
    input  logic             rst,
    input  logic             inReq,
    input  uopPkg::DecUop    inUop,
    output logic             inAck,
    output logic             outReq,
    output uopPkg::RenUop    outUop,
    input  logic             outAck,
    input  renamePkg::WbPort wbIn,
    input  uopPkg::CommitUop commitIn
);

    logic          bufValid;
    uopPkg::DecUop bufUop;
    logic          take;
    logic          senderFree;
    logic          issueValid;
    uopPkg::RenUop issueUop;

    uopReceiver receiver0 (
        .clk(clk),
        .rst(rst),
        .inReq(inReq),
        .inUop(inUop),
        .inAck(inAck),
        .take(take),
        .bufValid(bufValid),
        .bufUop(bufUop)
    );

    renameCore core0 (
        .clk(clk),
        .rst(rst),
        .bufValid(bufValid),
        .bufUop(bufUop),
        .take(take),
        .senderFree(senderFree),
        .issueValid(issueValid),
        .issueUop(issueUop),
        .wbIn(wbIn),
        .commitIn(commitIn)
    );

    uopSender sender0 (
        .clk(clk),
        .rst(rst),
        .issueValid(issueValid),
        .issueUop(issueUop),
        .senderFree(senderFree),
        .outReq(outReq),
        .outUop(outUop),
        .outAck(outAck)
    );

endmodule

/* logic/rename_cfg.svh */
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// Architectural register file
`define NUM_ARCH_REGS 16
`define ARCH_W 4

// Physical register file
`define NUM_TAGS 32
`define TAG_W 5

// Sequence number width
`define SQN_W 8

// Immediate carried by each micro-op
`define IMM_W 16

`endif

/* logic/tagBuffer.sv */
`timescale 1ns/1ns

`include "rename_cfg.svh"

module tagBuffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              pop,
    output logic [`TAG_W-1:0] freeTag,
    output logic              freeAvail,
    input  logic              push,
    input  logic [`TAG_W-1:0] pushTag
);

    // Entries hold the tag number without the flag bit
    localparam int ENTRY_W = $bits(renamePkg::Tag) - 1;
    // Every tag beyond the initial mappings starts out free
    localparam int DEPTH = `NUM_TAGS - `NUM_ARCH_REGS;
    localparam int PTR_W = $clog2(DEPTH);

    logic [ENTRY_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]   rdPtr;
    logic [PTR_W-1:0]   wrPtr;
    logic [PTR_W:0]     count;

    assign freeTag = mem[rdPtr];
    assign freeAvail = (count != '0);

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        nextPtr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            // Fill with the free tags in ascending order
            for (int i = 0; i < DEPTH; i++)
                mem[i] <= ENTRY_W'(`NUM_ARCH_REGS + i);
            rdPtr <= '0;
            wrPtr <= '0;
            count <= (PTR_W + 1)'(DEPTH);
        end else begin
            if (push) begin
                mem[wrPtr] <= pushTag;
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop)
                rdPtr <= nextPtr(rdPtr);

            // Simultaneous push and pop leave the fill level alone
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

endmodule

/* logic/uopPkg.sv */
`include "rename_cfg.svh"

package uopPkg;

    typedef enum logic [1:0] {
        FU_INT,
        FU_LI,
        FU_MEM,
        FU_BRANCH
    } FuType;

    // Micro-op as it comes out of decode
    typedef struct packed {
        logic [`ARCH_W-1:0] rs1;
        logic [`ARCH_W-1:0] rs2;
        logic [`ARCH_W-1:0] rd;
        logic [`IMM_W-1:0]  imm;
        FuType              fu;
    } DecUop;

    // Micro-op after renaming
    typedef struct packed {
        renamePkg::Tag      tagA;
        logic               availA;
        renamePkg::Tag      tagB;
        logic               availB;
        renamePkg::Tag      tagDst;
        renamePkg::Tag      prevTag;
        logic [`ARCH_W-1:0] rd;
        renamePkg::SqN      sqN;
        logic [`IMM_W-1:0]  imm;
        FuType              fu;
    } RenUop;

    // In-order commit pulse
    typedef struct packed {
        logic               valid;
        logic [`ARCH_W-1:0] rd;
        renamePkg::Tag      tagDst;
    } CommitUop;

endpackage

/* logic/uopReceiver.sv */
`timescale 1ns/1ns

module uopReceiver (
    input  logic          clk,
    input  logic          rst,
    input  logic          inReq,
    input  uopPkg::DecUop inUop,
    output logic          inAck,
    input  logic          take,
    output logic          bufValid,
    output uopPkg::DecUop bufUop
);

    renamePkg::LinkState state;

    // Ack stays high until the source drops its request
    assign inAck = (state == renamePkg::BUSY);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= renamePkg::IDLE;
            bufValid <= 1'b0;
        end else begin
            unique case (state)
                renamePkg::IDLE: begin
                    // Only accept a new op once the core has drained the buffer
                    if (inReq && !bufValid) begin
                        state <= renamePkg::BUSY;
                        bufValid <= 1'b1;
                    end
                end
                default: begin
                    if (!inReq)
                        state <= renamePkg::IDLE;
                end
            endcase
            if (take)
                bufValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == renamePkg::IDLE && inReq && !bufValid)
            bufUop <= inUop;
    end

endmodule

/* logic/uopSender.sv */
`timescale 1ns/1ns

module uopSender (
    input  logic          clk,
    input  logic          rst,
    input  logic          issueValid,
    input  uopPkg::RenUop issueUop,
    output logic          senderFree,
    output logic          outReq,
    output uopPkg::RenUop outUop,
    input  logic          outAck
);

    renamePkg::LinkState state;

    assign outReq = (state == renamePkg::BUSY);
    // Not free in the cycle an op is arriving either
    assign senderFree = (state == renamePkg::IDLE) && !issueValid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= renamePkg::IDLE;
        end else begin
            unique case (state)
                renamePkg::IDLE: begin
                    if (issueValid)
                        state <= renamePkg::BUSY;
                end
                renamePkg::BUSY: begin
                    if (outAck)
                        state <= renamePkg::WAIT_LOW;
                end
                default: begin
                    // Sink has to release its ack before the next op
                    if (!outAck)
                        state <= renamePkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == renamePkg::IDLE && issueValid)
            outUop <= issueUop;
    end

endmodule

/* testbench/renameChecker.sv */
`timescale 1ns/1ns

`include "rename_cfg.svh"

module renameChecker (
    input  logic             clk,
    input  logic             rst,
    input  logic             inReq,
    input  logic             inAck,
    input  uopPkg::DecUop    inUop,
    input  logic             outReq,
    input  logic             outAck,
    input  uopPkg::RenUop    outUop,
    input  renamePkg::WbPort wbIn,
    input  uopPkg::CommitUop commitIn,
    output int               outCount,
    output int               errCount
);

    // Model of the rename state
    renamePkg::Tag     specTag [`NUM_ARCH_REGS];
    logic              specReady [`NUM_ARCH_REGS];
    renamePkg::Tag     commTag [`NUM_ARCH_REGS];
    logic [`TAG_W-1:0] freeQ [$];
    renamePkg::SqN     sqModel;
    uopPkg::DecUop     accepted [$];
    // Data of the latest request, recorded once the ack rises
    uopPkg::DecUop     reqUop;
    logic              inAckSeen;
    logic              outAckSeen;

    function automatic uopPkg::RenUop predict(input uopPkg::DecUop u);
        uopPkg::RenUop r;
        logic          isLi;
        logic          needTag;
        isLi = (u.fu == uopPkg::FU_LI);
        needTag = (u.rd != '0) && !isLi;
        r.tagA = (u.rs1 == '0) ? renamePkg::TAG_ZERO : specTag[u.rs1];
        r.availA = (u.rs1 == '0) ? 1'b1 : specReady[u.rs1];
        r.tagB = (u.rs2 == '0) ? renamePkg::TAG_ZERO : specTag[u.rs2];
        r.availB = (u.rs2 == '0) ? 1'b1 : specReady[u.rs2];
        r.prevTag = (u.rd == '0) ? renamePkg::TAG_ZERO : specTag[u.rd];
        if (needTag) begin
            if (freeQ.size() == 0) begin
                $display("error at %0t: op renamed while no tag was free", $time);
                errCount++;
                r.tagDst = '0;
            end else begin
                r.tagDst = {1'b0, freeQ.pop_front()};
            end
        end else if (isLi) begin
            r.tagDst = {1'b1, u.imm[`TAG_W-1:0]};
        end else begin
            r.tagDst = renamePkg::TAG_ZERO;
        end
        r.rd = u.rd;
        r.sqN = sqModel;
        r.imm = u.imm;
        r.fu = u.fu;
        sqModel = sqModel + 1'b1;
        if (u.rd != '0) begin
            specTag[u.rd] = r.tagDst;
            specReady[u.rd] = isLi;
        end
        return r;
    endfunction

    always @(posedge clk) begin
        uopPkg::RenUop   expUop;
        renamePkg::Tag   oldTag;
        if (rst) begin
            for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
                specTag[i] = renamePkg::Tag'(i);
                specReady[i] = 1'b1;
                commTag[i] = renamePkg::Tag'(i);
            end
            freeQ.delete();
            for (int i = `NUM_ARCH_REGS; i < `NUM_TAGS; i++)
                freeQ.push_back(`TAG_W'(i));
            accepted.delete();
            reqUop = '0;
            sqModel = '0;
            inAckSeen = 1'b0;
            outAckSeen = 1'b0;
            outCount = 0;
            errCount = 0;
        end else begin
            if (wbIn.valid && !wbIn.tag[`TAG_W]) begin
                for (int i = 1; i < `NUM_ARCH_REGS; i++)
                    if (specTag[i] == wbIn.tag)
                        specReady[i] = 1'b1;
            end
            if (commitIn.valid && commitIn.rd != '0) begin
                oldTag = commTag[commitIn.rd];
                commTag[commitIn.rd] = commitIn.tagDst;
                // Special tags never go back to the free list
                if (!oldTag[`TAG_W])
                    freeQ.push_back(oldTag[`TAG_W-1:0]);
            end
            // The source may already have dropped its request when the ack shows up
            if (inAck && !inAckSeen)
                accepted.push_back(reqUop);
            inAckSeen = inAck;
            if (inReq)
                reqUop = inUop;
            if (outReq && outAck && !outAckSeen) begin
                outCount++;
                if (accepted.size() == 0) begin
                    $display("error at %0t: op output that was never accepted", $time);
                    errCount++;
                end else begin
                    expUop = predict(accepted.pop_front());
                    if (outUop !== expUop) begin
                        $display("error at %0t: op %0d expected %h got %h",
                                 $time, expUop.sqN, expUop, outUop);
                        errCount++;
                    end
                end
            end
            outAckSeen = outAck;
        end
    end

endmodule

/* testbench/renameTb.sv */
`timescale 1ns/1ns

`include "rename_cfg.svh"

module renameTb;

    localparam int TOTAL_OPS = 78;
    localparam int RESET_CYCLES = 8;

    logic             clk;
    logic             rst;
    logic             inReq;
    uopPkg::DecUop    inUop;
    logic             inAck;
    logic             outReq;
    uopPkg::RenUop    outUop;
    logic             outAck;
    renamePkg::WbPort wbIn;
    uopPkg::CommitUop commitIn;
    int               outCount;
    int               checkErrors;
    int               benchErrors;
    int               sentCount;
    int               stallMax;
    int               holdLeft;
    int               seedVal;
    uopPkg::RenUop    retired [$];

    renameTop dut0 (
        .clk(clk),
        .rst(rst),
        .inReq(inReq),
        .inUop(inUop),
        .inAck(inAck),
        .outReq(outReq),
        .outUop(outUop),
        .outAck(outAck),
        .wbIn(wbIn),
        .commitIn(commitIn)
    );

    renameChecker checker0 (
        .clk(clk),
        .rst(rst),
        .inReq(inReq),
        .inAck(inAck),
        .inUop(inUop),
        .outReq(outReq),
        .outAck(outAck),
        .outUop(outUop),
        .wbIn(wbIn),
        .commitIn(commitIn),
        .outCount(outCount),
        .errCount(checkErrors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Sink side, optionally holding off its ack
    initial begin
        outAck = 1'b0;
        holdLeft = 0;
        forever begin
            @(negedge clk);
            if (outReq && !outAck) begin
                if (holdLeft == 0) begin
                    outAck = 1'b1;
                    retired.push_back(outUop);
                    holdLeft = (stallMax > 0) ? $urandom_range(0, stallMax) : 0;
                end else begin
                    holdLeft--;
                end
            end else if (!outReq && outAck) begin
                outAck = 1'b0;
            end
        end
    end

    initial begin
        #((TOTAL_OPS * 40 + RESET_CYCLES) * 10);
        $display("Timeout: the rename stage stopped making progress");
        $display("Simulation FAILED");
        $finish;
    end

    task automatic sendOp(input logic [3:0] rs1, input logic [3:0] rs2,
                          input logic [3:0] rd, input uopPkg::FuType fu);
        @(negedge clk);
        inUop = '{rs1: rs1, rs2: rs2, rd: rd, imm: 16'($urandom), fu: fu};
        inReq = 1'b1;
        while (!inAck)
            @(negedge clk);
        inReq = 1'b0;
        sentCount++;
        while (inAck)
            @(negedge clk);
    endtask

    task automatic sendRandom();
        uopPkg::FuType fu;
        case ($urandom_range(0, 2))
            0: fu = uopPkg::FU_INT;
            1: fu = uopPkg::FU_MEM;
            default: fu = uopPkg::FU_BRANCH;
        endcase
        sendOp(4'($urandom), 4'($urandom), 4'($urandom), fu);
    endtask

    task automatic drain();
        while (outCount != sentCount || outReq || outAck)
            @(negedge clk);
    endtask

    task automatic commitOldest();
        uopPkg::RenUop r;
        r = retired.pop_front();
        @(negedge clk);
        commitIn = '{valid: 1'b1, rd: r.rd, tagDst: r.tagDst};
        @(negedge clk);
        commitIn = '0;
    endtask

    task automatic commitAll();
        while (retired.size() > 0)
            commitOldest();
    endtask

    task automatic writeBack(input renamePkg::Tag t);
        @(negedge clk);
        wbIn = '{valid: 1'b1, tag: t};
        @(negedge clk);
        wbIn = '0;
    endtask

    initial begin
        seedVal = $urandom(32'h25e4_e50c);
        rst = 1'b1;
        inReq = 1'b0;
        inUop = '0;
        wbIn = '0;
        commitIn = '0;
        benchErrors = 0;
        sentCount = 0;
        stallMax = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // Random integer ops, then register 0 on both sides
        for (int i = 0; i < 10; i++)
            sendRandom();
        sendOp(4'd0, 4'd0, 4'd0, uopPkg::FU_INT);
        drain();
        commitAll();

        // Load-immediate, its reader, then a real mapping for r5 again
        sendOp(4'd1, 4'd2, 4'd5, uopPkg::FU_LI);
        sendOp(4'd5, 4'd3, 4'd6, uopPkg::FU_INT);
        sendOp(4'd5, 4'd0, 4'd5, uopPkg::FU_INT);
        drain();

        // Not ready until written back
        sendOp(4'd1, 4'd2, 4'd7, uopPkg::FU_INT);
        drain();
        sendOp(4'd7, 4'd7, 4'd8, uopPkg::FU_INT);
        drain();
        writeBack(retired[retired.size() - 2].tagDst);
        sendOp(4'd7, 4'd8, 4'd9, uopPkg::FU_INT);
        drain();
        commitAll();

        // Exhaust the tag buffer
        for (int i = 0; i < 16; i++)
            sendOp(4'($urandom), 4'($urandom), 4'(1 + i % 15), uopPkg::FU_INT);
        drain();
        sendOp(4'd3, 4'd4, 4'd10, uopPkg::FU_INT);
        repeat (20) @(negedge clk);
        if (outCount != sentCount - 1) begin
            $display("error at %0t: op output while the tag buffer was empty", $time);
            benchErrors++;
        end
        commitOldest();
        drain();
        commitAll();
        for (int i = 0; i < 4; i++)
            sendRandom();
        drain();
        commitAll();

        // Back-pressure from the sink
        stallMax = 6;
        for (int b = 0; b < 5; b++) begin
            for (int i = 0; i < 8; i++)
                sendRandom();
            drain();
            commitAll();
        end

        repeat (5) @(negedge clk);
        $display("Errors: checker %0d, testbench %0d", checkErrors, benchErrors);
        if (checkErrors == 0 && benchErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
